// ==== rtl/pyon_pkg.sv ====
package pyon_pkg;

  // ---------------------------------------------------------------------
  // game types
  // ---------------------------------------------------------------------

  typedef logic [3:0] bcd_digit_t;  // one decimal digit

  typedef struct packed {
    bcd_digit_t tens;  // upper digit
    bcd_digit_t ones;  // lower digit
  } score_t;

  typedef logic [6:0] seg_t;  // active low, bit 6 = segment g

  typedef struct packed {
    seg_t timer_ones;
    seg_t timer_tens;
    seg_t cpu_ones;
    seg_t cpu_tens;
    seg_t player_ones;
    seg_t player_tens;
  } display_t;

  typedef struct packed {
    logic left;   // high while pressed
    logic right;  // high while pressed
  } keys_t;

  typedef logic [1:0] speed_t;  // 0 1.5 Hz, 1 2 Hz, 2 3 Hz, 3 5 Hz

  typedef struct packed {
    logic player_won;
    logic cpu_won;
  } result_t;

  // ---------------------------------------------------------------------
  // game constants
  // ---------------------------------------------------------------------

  localparam int unsigned box_count = 32;  // boxes in the race

  // bit 0 is the first box, 1 = right
  localparam logic [box_count-1:0] box_pattern = 32'hd15d_9689;

  localparam score_t score_start = '{tens: 4'd3, ones: 4'd2};  // 32 boxes left

  localparam int unsigned board_sec_cycles = 50_000_000;  // 50 MHz board clock

endpackage

// ==== rtl/key_press_sync.sv ====
`timescale 1ns/1ps

module key_press_sync (
  input  logic            clk,
  input  logic            rst,
  input  pyon_pkg::keys_t keys,         // raw buttons, asynchronous
  output logic            left_press,   // one cycle per left press
  output logic            right_press   // one cycle per right press
);

  // ---------------------------------------------------------------------
  // two-flop synchronizer plus one delay flop for edge detect
  // ---------------------------------------------------------------------

  pyon_pkg::keys_t meta_q;  // first stage, may go metastable
  pyon_pkg::keys_t sync_q;  // safe to use from here on
  pyon_pkg::keys_t dly_q;   // previous synced level

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      meta_q      <= '0;
      sync_q      <= '0;
      dly_q       <= '0;
      left_press  <= 1'b0;
      right_press <= 1'b0;
    end else begin
      meta_q <= keys;    // sample async buttons
      sync_q <= meta_q;  // settle
      dly_q  <= sync_q;  // one cycle behind

      // rising edge only, so holding a key gives one strobe
      left_press  <= sync_q.left & ~dly_q.left;
      right_press <= sync_q.right & ~dly_q.right;
    end
  end

endmodule

// ==== rtl/box_queue.sv ====
`timescale 1ns/1ps

module box_queue (
  input  logic clk,
  input  logic rst,
  input  logic run,          // game running
  input  logic left_press,   // left key strobe
  input  logic right_press,  // right key strobe
  output logic hit           // correct key on the head box
);

  // ---------------------------------------------------------------------
  // box pattern, head box sits in bit 0
  // ---------------------------------------------------------------------

  logic [pyon_pkg::box_count-1:0] pattern_q;  // remaining boxes
  logic                           head;       // 1 = right, 0 = left
  logic                           right_ok;   // right key on a right box
  logic                           left_ok;    // left key on a left box

  assign head     = pattern_q[0];
  assign right_ok = right_press & head;
  assign left_ok  = left_press & ~head;
  assign hit      = run & (right_ok | left_ok);  // same cycle as the strobe

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pattern_q <= pyon_pkg::box_pattern;  // fresh course
    end else if (hit) begin
      // next box moves to the head, empty slot fills with 0
      pattern_q <= {1'b0, pattern_q[pyon_pkg::box_count-1:1]};
    end
    // a wrong key leaves the queue alone
  end

endmodule

// ==== rtl/tick_divider.sv ====
`timescale 1ns/1ps

module tick_divider #(
  parameter int unsigned period = pyon_pkg::board_sec_cycles  // cycles per tick
) (
  input  logic clk,
  input  logic rst,
  input  logic run,   // count only while high
  output logic tick   // one cycle every period cycles
);

  localparam int unsigned     cnt_w  = (period > 1) ? $clog2(period) : 1;
  localparam logic [cnt_w-1:0] reload = cnt_w'(period - 1);

  logic [cnt_w-1:0] cnt_q;  // cycles left in this period

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt_q <= reload;
      tick  <= 1'b0;
    end else begin
      tick <= 1'b0;  // strobe by default
      if (run) begin
        if (cnt_q == '0) begin
          cnt_q <= reload;  // wrap
          tick  <= 1'b1;
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
      // run low holds the count where it is
    end
  end

endmodule

// ==== rtl/cpu_pacer.sv ====
`timescale 1ns/1ps

module cpu_pacer #(
  parameter int unsigned sec_cycles = pyon_pkg::board_sec_cycles  // cycles per second
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             run,    // count only while high
  input  pyon_pkg::speed_t speed,  // opponent rate select
  output logic             tick    // one cycle per opponent step
);

  // ---------------------------------------------------------------------
  // periods as fractions of one second
  // ---------------------------------------------------------------------

  localparam int unsigned period_0 = sec_cycles * 2 / 3;  // 1.5 Hz
  localparam int unsigned period_1 = sec_cycles / 2;      // 2 Hz
  localparam int unsigned period_2 = sec_cycles / 3;      // 3 Hz
  localparam int unsigned period_3 = sec_cycles / 5;      // 5 Hz

  localparam int unsigned cnt_w = (sec_cycles > 1) ? $clog2(sec_cycles) : 1;

  logic [cnt_w-1:0] cnt_q;   // cycles left in this period
  logic [cnt_w-1:0] reload;  // next period from current speed

  always_comb begin
    case (speed)
      2'd0:    reload = cnt_w'(period_0 - 1);
      2'd1:    reload = cnt_w'(period_1 - 1);
      2'd2:    reload = cnt_w'(period_2 - 1);
      default: reload = cnt_w'(period_3 - 1);
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt_q <= cnt_w'(period_0 - 1);  // start at the slowest rate
      tick  <= 1'b0;
    end else begin
      tick <= 1'b0;
      if (run) begin
        if (cnt_q == '0) begin
          cnt_q <= reload;  // speed picked up here
          tick  <= 1'b1;
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

endmodule

// ==== rtl/bcd_counter.sv ====
`timescale 1ns/1ps

module bcd_counter #(
  parameter bit count_up = 1'b1  // 1 timer style, 0 score style
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             step,   // advance by one
  output pyon_pkg::score_t value   // two bcd digits
);

  localparam pyon_pkg::score_t reset_value =
    count_up ? pyon_pkg::score_t'(8'h00) : pyon_pkg::score_start;

  pyon_pkg::score_t next;  // value after one step

  // ---------------------------------------------------------------------
  // next value with decimal carry or borrow
  // ---------------------------------------------------------------------

  always_comb begin
    next = value;
    if (count_up) begin
      if (value.ones == 4'd9) begin
        next.ones = 4'd0;  // X9 -> (X+1)0
        next.tens = (value.tens == 4'd9) ? 4'd0 : value.tens + 4'd1;  // 99 -> 00
      end else begin
        next.ones = value.ones + 4'd1;
      end
    end else begin
      if (value == pyon_pkg::score_t'(8'h00)) begin
        next = value;  // empty, stay at 00
      end else if (value.ones == 4'd0) begin
        next.ones = 4'd9;  // X0 -> (X-1)9
        next.tens = value.tens - 4'd1;
      end else begin
        next.ones = value.ones - 4'd1;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      value <= reset_value;
    end else if (step) begin
      value <= next;
    end
  end

endmodule

// ==== rtl/referee.sv ====
`timescale 1ns/1ps

module referee (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,         // game switch
  input  logic              sec_tick,      // one second elapsed
  input  logic              cpu_tick,      // opponent wants a step
  input  pyon_pkg::score_t  player_score,
  input  pyon_pkg::score_t  cpu_score,
  output logic              run,           // game running
  output logic              timer_step,    // advance elapsed time
  output logic              cpu_step,      // lower opponent count
  output pyon_pkg::result_t result         // latched winner
);

  logic player_done;  // player count at 00
  logic cpu_done;     // opponent count at 00
  logic over;         // someone finished

  assign player_done = (player_score == pyon_pkg::score_t'(8'h00));
  assign cpu_done    = (cpu_score == pyon_pkg::score_t'(8'h00));
  assign over        = player_done | cpu_done;

  // no steps once a count hits 00, even before run drops
  assign timer_step = run & sec_tick & ~over;
  assign cpu_step   = run & cpu_tick & ~over;

  // ---------------------------------------------------------------------
  // run state and winner latch
  // ---------------------------------------------------------------------

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      run    <= 1'b0;
      result <= '0;
    end else begin
      // winner locks the game until reset
      run <= start & ~over & (result == '0);
      if (result == '0) begin
        result.player_won <= player_done;  // both set on a tie
        result.cpu_won    <= cpu_done;
      end
    end
  end

endmodule

// ==== rtl/seg7_display.sv ====
`timescale 1ns/1ps

module seg7_display (
  input  pyon_pkg::score_t   timer,   // elapsed seconds
  input  pyon_pkg::score_t   cpu,     // opponent count
  input  pyon_pkg::score_t   player,  // player count
  output pyon_pkg::display_t hex      // six active low digits
);

  // ---------------------------------------------------------------------
  // one digit to segments, bit 6 = g, low lights the segment
  // ---------------------------------------------------------------------

  function automatic pyon_pkg::seg_t seg_of(pyon_pkg::bcd_digit_t d);
    pyon_pkg::seg_t s;
    case (d)
      4'd0:    s = 7'b100_0000;
      4'd1:    s = 7'b111_1001;
      4'd2:    s = 7'b010_0100;
      4'd3:    s = 7'b011_0000;
      4'd4:    s = 7'b001_1001;
      4'd5:    s = 7'b001_0010;
      4'd6:    s = 7'b000_0010;
      4'd7:    s = 7'b111_1000;
      4'd8:    s = 7'b000_0000;
      4'd9:    s = 7'b001_0000;
      default: s = 7'b100_0000;  // non-decimal shows 0
    endcase
    return s;
  endfunction

  assign hex.timer_ones  = seg_of(timer.ones);
  assign hex.timer_tens  = seg_of(timer.tens);
  assign hex.cpu_ones    = seg_of(cpu.ones);
  assign hex.cpu_tens    = seg_of(cpu.tens);
  assign hex.player_ones = seg_of(player.ones);
  assign hex.player_tens = seg_of(player.tens);

endmodule

// ==== rtl/pyonpyon_top.sv ====
`timescale 1ns/1ps

module pyonpyon_top #(
  parameter int unsigned sec_cycles = pyon_pkg::board_sec_cycles  // clock cycles per second
) (
  input  logic               clk,
  input  logic               rst,     // async, active high
  input  logic               start,   // game switch
  input  pyon_pkg::speed_t   speed,   // opponent rate
  input  pyon_pkg::keys_t    keys,    // left and right buttons
  output pyon_pkg::display_t hex,     // seven segment digits
  output pyon_pkg::result_t  result   // winner lamps
);

  logic             left_press;    // press strobes
  logic             right_press;
  logic             hit;           // correct key
  logic             run;           // game running
  logic             sec_tick;      // raw second tick
  logic             cpu_tick;      // raw opponent tick
  logic             timer_step;    // gated second
  logic             cpu_step;      // gated opponent step
  pyon_pkg::score_t timer_value;   // elapsed seconds
  pyon_pkg::score_t cpu_score;     // opponent boxes left
  pyon_pkg::score_t player_score;  // player boxes left

  // ---------------------------------------------------------------------
  // player path
  // ---------------------------------------------------------------------

  key_press_sync u_key_press_sync (
    .clk         (clk),
    .rst         (rst),
    .keys        (keys),
    .left_press  (left_press),
    .right_press (right_press)
  );

  box_queue u_box_queue (
    .clk         (clk),
    .rst         (rst),
    .run         (run),
    .left_press  (left_press),
    .right_press (right_press),
    .hit         (hit)
  );

  bcd_counter #(.count_up(1'b0)) u_player_cnt (
    .clk   (clk),
    .rst   (rst),
    .step  (hit),
    .value (player_score)
  );

  // ---------------------------------------------------------------------
  // time base and opponent
  // ---------------------------------------------------------------------

  tick_divider #(.period(sec_cycles)) u_tick_divider (
    .clk  (clk),
    .rst  (rst),
    .run  (run),
    .tick (sec_tick)
  );

  cpu_pacer #(.sec_cycles(sec_cycles)) u_cpu_pacer (
    .clk   (clk),
    .rst   (rst),
    .run   (run),
    .speed (speed),
    .tick  (cpu_tick)
  );

  bcd_counter #(.count_up(1'b1)) u_timer_cnt (
    .clk   (clk),
    .rst   (rst),
    .step  (timer_step),
    .value (timer_value)
  );

  bcd_counter #(.count_up(1'b0)) u_cpu_cnt (
    .clk   (clk),
    .rst   (rst),
    .step  (cpu_step),
    .value (cpu_score)
  );

  // ---------------------------------------------------------------------
  // game control and display
  // ---------------------------------------------------------------------

  referee u_referee (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .sec_tick     (sec_tick),
    .cpu_tick     (cpu_tick),
    .player_score (player_score),
    .cpu_score    (cpu_score),
    .run          (run),
    .timer_step   (timer_step),
    .cpu_step     (cpu_step),
    .result       (result)
  );

  seg7_display u_seg7_display (
    .timer  (timer_value),
    .cpu    (cpu_score),
    .player (player_score),
    .hex    (hex)
  );

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter int half_ns      = 2,   // 4 ns period
  parameter int reset_cycles = 16   // cycles rst stays high
) (
  input  logic reset_req,  // rising edge starts another reset
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(half_ns) clk = ~clk;
  end

  initial begin
    rst = 1'b1;  // power-on reset
    forever begin
      repeat (reset_cycles) @(posedge clk);
      #1 rst = 1'b0;  // release just after an edge
      @(posedge reset_req);
      rst = 1'b1;
    end
  end

endmodule

// ==== verification/tb_pyonpyon.sv ====
`timescale 1ns/1ps

module tb_pyonpyon;

  typedef struct packed {
    pyon_pkg::score_t timer;
    pyon_pkg::score_t cpu;
    pyon_pkg::score_t player;
  } scores_t;  // display read back as digits

  // segment table, index = digit, low lights a segment, bit 6 = g
  localparam logic [9:0][6:0] seg_ref = {
    7'b001_0000, 7'b000_0000, 7'b111_1000, 7'b000_0010, 7'b001_0010,
    7'b001_1001, 7'b011_0000, 7'b010_0100, 7'b111_1001, 7'b100_0000
  };

  localparam int sec_cycles   = 60;  // short second for simulation
  localparam int rand_presses = 12;
  localparam int test_cycles  = 16 + 300 + rand_presses * 28 + 100
                                + (32 * 40 + 200) + (16 + 32 * 8 + 20);
  localparam int cycle_limit  = 4 * test_cycles;

  logic               clk;
  logic               rst;
  logic               reset_req;
  logic               start;
  pyon_pkg::speed_t   speed;
  pyon_pkg::keys_t    keys;
  pyon_pkg::display_t hex;
  pyon_pkg::result_t  result;

  logic [31:0]      model_pattern;  // head box in bit 0
  int               model_left;     // boxes the player still has
  pyon_pkg::score_t exp_player;
  logic             hold_player;    // player score must match while high
  logic [31:0]      rng_state;
  int               cycle_cnt = 0;
  int               start_cycle;    // cycle_cnt when start went high
  scores_t          watch_seen;

  tb_clock u_tb_clock (
    .reset_req (reset_req),
    .clk       (clk),
    .rst       (rst)
  );

  pyonpyon_top #(.sec_cycles(sec_cycles)) u_pyonpyon_top (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .speed  (speed),
    .keys   (keys),
    .hex    (hex),
    .result (result)
  );

  // ---------------------------------------------------------------------
  // reference model
  // ---------------------------------------------------------------------

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic pyon_pkg::bcd_digit_t seg_to_digit(input pyon_pkg::seg_t s);
    int d;
    for (d = 0; d < 10; d++) begin
      if (seg_ref[d] == s) return 4'(d);
    end
    return 4'hf;  // not a digit pattern
  endfunction

  function automatic scores_t decode_display(input pyon_pkg::display_t d);
    scores_t s;
    s.timer.ones  = seg_to_digit(d.timer_ones);
    s.timer.tens  = seg_to_digit(d.timer_tens);
    s.cpu.ones    = seg_to_digit(d.cpu_ones);
    s.cpu.tens    = seg_to_digit(d.cpu_tens);
    s.player.ones = seg_to_digit(d.player_ones);
    s.player.tens = seg_to_digit(d.player_tens);
    return s;
  endfunction

  function automatic pyon_pkg::score_t expected_score(input int n);
    pyon_pkg::score_t s;
    s.tens = 4'(n / 10);
    s.ones = 4'(n % 10);
    return s;
  endfunction

  function automatic logic press_matches(input logic head, input logic is_right);
    return head == is_right;  // 1 = right box
  endfunction

  // ---------------------------------------------------------------------
  // compare tasks
  // ---------------------------------------------------------------------

  task automatic check_score(input string name, input pyon_pkg::score_t got,
                             input pyon_pkg::score_t exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h", name, got, exp);
      $display("Simulation failed");
      $fatal(1, "score mismatch");
    end
  endtask

  task automatic check_result(input string name, input pyon_pkg::result_t got,
                              input pyon_pkg::result_t exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h", name, got, exp);
      $display("Simulation failed");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic check_hex(input string name, input pyon_pkg::seg_t got,
                           input pyon_pkg::seg_t exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h", name, got, exp);
      $display("Simulation failed");
      $fatal(1, "segment mismatch");
    end
  endtask

  task automatic check_reset_state();
    pyon_pkg::result_t none;
    none = '0;
    check_hex("hex.timer_ones", hex.timer_ones, seg_ref[0]);
    check_hex("hex.timer_tens", hex.timer_tens, seg_ref[0]);
    check_hex("hex.cpu_ones", hex.cpu_ones, seg_ref[2]);
    check_hex("hex.cpu_tens", hex.cpu_tens, seg_ref[3]);
    check_hex("hex.player_ones", hex.player_ones, seg_ref[2]);
    check_hex("hex.player_tens", hex.player_tens, seg_ref[3]);
    check_result("result", result, none);
  endtask

  // ---------------------------------------------------------------------
  // stimulus helpers, all drives land 1 ns after a rising edge
  // ---------------------------------------------------------------------

  task automatic step_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic draw_random(input int lo, input int span, output int val);
    rng_state = next_rand(rng_state);
    val = lo + int'(rng_state % span);
  endtask

  task automatic press_key(input logic is_right, input int hold);
    keys.left  = ~is_right;
    keys.right = is_right;
    step_cycles(hold);
    keys = '0;  // release
  endtask

  always @(negedge clk) begin
    if (hold_player) begin
      watch_seen = decode_display(hex);
      check_score("hex player score", watch_seen.player, exp_player);
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("run did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    int                i;
    int                pick;
    int                hold;
    int                gap;
    int                w;
    int                timer_val;
    logic              is_right;
    logic              hit_now;
    scores_t           seen;
    pyon_pkg::score_t  timer_snap;
    pyon_pkg::result_t exp_res;

    start         = 1'b0;
    speed         = 2'd0;
    keys          = '0;
    reset_req     = 1'b0;
    hold_player   = 1'b0;
    rng_state     = 32'heb1bf8c5;
    model_pattern = pyon_pkg::box_pattern;
    model_left    = 32;
    exp_player    = expected_score(32);
    @(negedge rst);
    check_reset_state();

    // start low, everything frozen
    hold_player = 1'b1;
    step_cycles(100);
    press_key(1'b1, 6);  // would hit the first box
    step_cycles(100);
    press_key(1'b0, 6);
    step_cycles(88);
    check_reset_state();

    // random presses at the slowest opponent rate
    start       = 1'b1;
    start_cycle = cycle_cnt;
    for (i = 0; i < rand_presses; i++) begin
      draw_random(0, 2, pick);
      draw_random(4, 8, hold);
      draw_random(4, 8, gap);
      is_right    = pick[0];
      hit_now     = press_matches(model_pattern[0], is_right);
      hold_player = 1'b0;  // score may move now
      press_key(is_right, hold);
      step_cycles(6);      // settle
      if (hit_now) begin
        model_pattern = model_pattern >> 1;
        model_left    = model_left - 1;
      end
      exp_player  = expected_score(model_left);
      hold_player = 1'b1;
      step_cycles(gap);
    end

    // elapsed seconds, one second of slack for divider latency
    step_cycles(100);
    w         = cycle_cnt - start_cycle;
    seen      = decode_display(hex);
    timer_val = seen.timer.tens * 10 + seen.timer.ones;
    if (timer_val == w / sec_cycles - 1) begin
      check_score("hex timer", seen.timer, expected_score(w / sec_cycles - 1));
    end else begin
      check_score("hex timer", seen.timer, expected_score(w / sec_cycles));
    end

    // opponent wins at the fastest rate
    speed = 2'd3;
    while (result == '0) step_cycles(1);
    exp_res.player_won = 1'b0;
    exp_res.cpu_won    = 1'b1;
    check_result("result", result, exp_res);
    seen = decode_display(hex);
    check_score("hex cpu score", seen.cpu, expected_score(0));
    timer_snap = seen.timer;
    for (i = 0; i < 10; i++) begin
      draw_random(0, 2, pick);
      press_key(pick[0], 8);  // ignored after the win
      step_cycles(12);
    end
    seen = decode_display(hex);
    check_score("hex timer", seen.timer, timer_snap);
    check_result("result", result, exp_res);

    // fresh game, player clears every box
    start       = 1'b0;
    speed       = 2'd0;
    hold_player = 1'b0;
    reset_req   = 1'b1;
    wait (rst === 1'b1);
    reset_req = 1'b0;
    wait (rst === 1'b0);
    model_pattern = pyon_pkg::box_pattern;
    model_left    = 32;
    check_reset_state();
    start = 1'b1;
    step_cycles(2);
    for (i = 0; i < pyon_pkg::box_count; i++) begin
      is_right = model_pattern[0];  // always the right key
      press_key(is_right, 4);
      step_cycles(4);
      model_pattern = model_pattern >> 1;
      model_left    = model_left - 1;
    end
    while (result == '0) step_cycles(1);
    exp_res.player_won = 1'b1;
    exp_res.cpu_won    = 1'b0;
    check_result("result", result, exp_res);
    exp_player = expected_score(model_left);
    seen       = decode_display(hex);
    check_score("hex player score", seen.player, exp_player);

    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== src.f ====
rtl/pyon_pkg.sv
rtl/key_press_sync.sv
rtl/box_queue.sv
rtl/tick_divider.sv
rtl/cpu_pacer.sv
rtl/bcd_counter.sv
rtl/referee.sv
rtl/seg7_display.sv
rtl/pyonpyon_top.sv
verification/tb_clock.sv
verification/tb_pyonpyon.sv
